/* hw/vfdPkg.sv */
// Frame geometry, scan timing constants, vector types and the scanner state enum.
package vfdPkg;

	// ==================================================
	// Frame geometry.
	// ==================================================
	localparam int frameBytes  = 3003; // Bytes in one host frame.
	localparam int rowBytes    = 77;   // Bytes per RAM row.
	localparam int rowCount    = 39;   // RAM rows.
	localparam int gridCount   = 52;   // Grids on the tube.

	// Serial stream of one grid.
	localparam int bitsPerGrid = 288;  // Bits shifted per grid.
	localparam int pixelBits   = 234;  // Leading pixel bits.
	localparam int gridBitBase = 234;  // First grid-enable bit.
	localparam int pixPerGroup = 6;    // A F B E C D, then next row.

	// ==================================================
	// Scan timing.
	// ==================================================
	localparam int blankLen    = 7;    // Cycles of blank per grid.
	localparam int latchStart  = 1;    // Latch rises here.
	localparam int latchEnd    = 5;    // Latch falls here.

	// GCP start bits, one per brightness step.
	localparam int gcpStarts [0:5] = '{72, 144, 192, 216, 240, 256};
	localparam int gcpWidth    = 3;    // Pulse width in bits.

	// Vector types.
	typedef logic [11:0] ramAddrT; // Frame RAM address.
	typedef logic [7:0]  ramByteT; // Two pixels, low six bits.
	typedef logic [5:0]  gridT;    // Grid number, 1 to 52.
	typedef logic [8:0]  bitIdxT;  // Bit within a grid.
	typedef logic [2:0]  pixSlotT; // Position in A F B E C D.
	typedef logic [2:0]  grayT;    // One bit per serial line.

	// Scanner states.
	typedef enum logic [2:0] {
		held,      // Display blanked, waiting on the host.
		blank,     // Blank and latch phase.
		fetch,     // RAM read issued.
		clockLow,  // Data settles.
		clockHigh  // Serial clock high.
	} scanStateT;

endpackage

/* hw/spiFrameLoader.sv */
// SPI slave front end: pin synchronizers, byte assembly and addressed frame RAM writes.
module spiFrameLoader
	import vfdPkg::*;
(
	input  logic    CLK,
	input  logic    arstN,
	input  logic    sdi,
	input  logic    sclk,
	input  logic    csN,
	output logic    wrEn,
	output ramAddrT wrAddr,
	output ramByteT wrData,
	output logic    loadActive
);

	logic [1:0] sdiSync;  // Two-flop synchronizers.
	logic [1:0] sclkSync;
	logic [1:0] csSync;
	logic       sclkPrev; // Last synchronized sclk.
	logic       sclkRise;
	logic       accept;   // Bit taken into the shifter.
	logic [2:0] bitCnt;
	ramAddrT    byteCnt;  // Saturates at frameBytes.
	ramByteT    shiftReg;
	logic       byteDone; // Byte complete, write next cycle.

	assign loadActive = ~csSync[1]; // Chip select low.
	assign sclkRise   = sclkSync[1] & ~sclkPrev;
	assign accept     = sclkRise && loadActive && (byteCnt != ramAddrT'(frameBytes));

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			sdiSync  <= '0;
			sclkSync <= '0;
			csSync   <= '1; // Idle host, deselected.
			sclkPrev <= 1'b0;
		end else begin
			sdiSync  <= {sdiSync[0], sdi};
			sclkSync <= {sclkSync[0], sclk};
			csSync   <= {csSync[0], csN};
			sclkPrev <= sclkSync[1];
		end
	end

	// ==================================================
	// Byte and address counting.
	// ==================================================
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			bitCnt   <= '0;
			byteCnt  <= '0;
			byteDone <= 1'b0;
			wrEn     <= 1'b0;
		end else begin
			wrEn     <= byteDone;
			byteDone <= accept && (bitCnt == 3'd7); // Eighth bit in.
			if (!loadActive) begin
				bitCnt  <= '0; // New frame starts at address 0.
				byteCnt <= '0;
			end else begin
				if (accept)
					bitCnt <= bitCnt + 1'b1;
				if (byteDone)
					byteCnt <= byteCnt + 1'b1;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (accept)
			shiftReg <= {shiftReg[6:0], sdiSync[1]}; // MSB first.
		if (byteDone) begin
			wrAddr <= byteCnt;
			wrData <= shiftReg;
		end
	end

endmodule

/* hw/frameRam.sv */
// Dual-port frame memory with registered read and single-cycle write.
module frameRam
	import vfdPkg::*;
(
	input  logic    CLK,
	input  logic    wrEn,
	input  ramAddrT wrAddr,
	input  ramByteT wrData,
	input  logic    rdEn,
	input  ramAddrT rdAddr,
	output ramByteT rdData
);

	ramByteT mem [frameBytes];

	// Blank picture until the first frame lands.
	initial begin
		for (int i = 0; i < frameBytes; i++)
			mem[i] = '0;
	end

	always @(posedge CLK) begin
		if (wrEn)
			mem[wrAddr] <= wrData;
	end

	// Last grid pair reaches one byte past the frame; it reads as blank.
	always_ff @(posedge CLK) begin
		if (rdEn)
			rdData <= (rdAddr < ramAddrT'(frameBytes)) ? mem[rdAddr] : '0;
	end

endmodule

/* hw/gridSequencer.sv */
// Scan FSM: grid, bit, pixel slot and row counters with blank, latch, clock and end-of-frame.
module gridSequencer
	import vfdPkg::*;
(
	input  logic       CLK,
	input  logic       arstN,
	input  logic       loadActive,
	output gridT       grid,
	output bitIdxT     bitIdx,
	output pixSlotT    pixSlot,
	output logic [5:0] row,
	output logic       fetchStb,
	output logic       blk,
	output logic       lat,
	output logic       sck,
	output logic       eof
);

	scanStateT  state;
	logic [2:0] phaseCnt; // Blank phase cycle.
	logic       lastBit;  // Bit 287 of the grid.
	logic       eofArm;   // Last clock of grid 52 on the pins.

	assign lastBit  = (bitIdx == bitIdxT'(bitsPerGrid - 1));
	assign fetchStb = (state == fetch);

	// ==================================================
	// State and counters.
	// ==================================================
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			state    <= held;
			phaseCnt <= '0;
			grid     <= gridT'(1);
			bitIdx   <= '0;
			pixSlot  <= '0;
			row      <= '0;
		end else if (loadActive) begin
			state    <= held; // Host owns the RAM, restart at grid 1.
			phaseCnt <= '0;
			grid     <= gridT'(1);
			bitIdx   <= '0;
			pixSlot  <= '0;
			row      <= '0;
		end else begin
			case (state)
				held: state <= blank;
				blank: begin
					if (phaseCnt == 3'(blankLen - 1)) begin
						phaseCnt <= '0;
						state    <= fetch;
					end else begin
						phaseCnt <= phaseCnt + 1'b1;
					end
				end
				fetch:    state <= clockLow;
				clockLow: state <= clockHigh;
				clockHigh: begin
					if (lastBit) begin
						bitIdx  <= '0;
						pixSlot <= '0;
						row     <= '0;
						state   <= blank;
						grid    <= (grid == gridT'(gridCount)) ? gridT'(1) : grid + 1'b1;
					end else begin
						bitIdx <= bitIdx + 1'b1;
						state  <= fetch;
						if (pixSlot == pixSlotT'(pixPerGroup - 1)) begin
							pixSlot <= '0;
							if (row != 6'(rowCount - 1)) // Parks on the last row.
								row <= row + 1'b1;
						end else begin
							pixSlot <= pixSlot + 1'b1;
						end
					end
				end
				default: state <= held;
			endcase
		end
	end

	// ==================================================
	// Registered display controls, one cycle behind state.
	// ==================================================
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			blk    <= 1'b1;
			lat    <= 1'b0;
			sck    <= 1'b0;
			eofArm <= 1'b0;
			eof    <= 1'b0;
		end else if (loadActive) begin
			blk    <= 1'b1; // Tube dark while loading.
			lat    <= 1'b0;
			sck    <= 1'b0;
			eofArm <= 1'b0;
			eof    <= 1'b0;
		end else begin
			blk    <= (state == held) || (state == blank);
			lat    <= (state == blank) && (phaseCnt >= latchStart) && (phaseCnt < latchEnd);
			sck    <= (state == clockHigh);
			eofArm <= (state == clockHigh) && lastBit && (grid == gridT'(gridCount));
			eof    <= eofArm; // Host may send the next frame.
		end
	end

endmodule

/* hw/pixelFetch.sv */
// RAM address generation, A F B E C D pixel pick with parity mask, and grid-enable bits.
module pixelFetch
	import vfdPkg::*;
(
	input  logic       CLK,
	input  logic       arstN,
	input  gridT       grid,
	input  bitIdxT     bitIdx,
	input  pixSlotT    pixSlot,
	input  logic [5:0] row,
	input  logic       fetchStb,
	input  ramByteT    rdData,
	output logic       rdEn,
	output ramAddrT    rdAddr,
	output grayT       sData
);

	ramAddrT    rowLut [rowCount];  // row * 77.
	ramAddrT    colLut [gridCount]; // Grid pair * 3.
	ramAddrT    slotByte;           // Byte within the pair's three.
	gridT       gridD;
	bitIdxT     bitIdxD;
	pixSlotT    slotD;
	logic [1:0] stbPipe;            // Data in, then hold.
	logic       upperHalf;
	logic       slotShown;
	bitIdxT     gridBitLo;
	grayT       pixVal;
	grayT       gridVal;

	for (genvar r = 0; r < rowCount; r++) begin : genRowLut
		assign rowLut[r] = ramAddrT'(r * rowBytes);
	end
	for (genvar g = 0; g < gridCount; g++) begin : genColLut
		assign colLut[g] = ramAddrT'((g / 2) * 3); // Grids 1 and 2 share bytes.
	end

	always_comb begin
		case (pixSlot)
			3'd0, 3'd2: slotByte = ramAddrT'(0); // A, B.
			3'd4, 3'd5: slotByte = ramAddrT'(1); // C, D.
			default:    slotByte = ramAddrT'(2); // F, E.
		endcase
	end

	assign rdAddr = slotByte + colLut[grid - gridT'(1)] + rowLut[row];
	assign rdEn   = fetchStb && (bitIdx < bitIdxT'(pixelBits)); // No read for grid bits.

	// Indices lined up with rdData.
	always_ff @(posedge CLK) begin
		gridD   <= grid;
		bitIdxD <= bitIdx;
		slotD   <= pixSlot;
	end

	// ==================================================
	// Output select.
	// ==================================================
	assign upperHalf = (slotD == 3'd0) || (slotD == 3'd3) || (slotD == 3'd4); // A, E, C.
	assign slotShown = slotD[0] ^ gridD[0]; // Odd grid shows A B C.
	assign pixVal    = slotShown ? (upperHalf ? rdData[5:3] : rdData[2:0]) : '0;

	// Grid g lights enable bits 233 + g and 234 + g.
	assign gridBitLo = bitIdxT'(gridBitBase) + bitIdxT'(gridD) - 1'b1;
	assign gridVal   = ((bitIdxD == gridBitLo) || (bitIdxD == gridBitLo + 1'b1)) ? '1 : '0;

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			stbPipe <= '0;
			sData   <= '0;
		end else begin
			stbPipe <= {stbPipe[0], fetchStb};
			if (stbPipe[0])
				sData <= (bitIdxD < bitIdxT'(pixelBits)) ? pixVal : gridVal;
			else if (!stbPipe[1])
				sData <= '0; // Idle between bits and while held.
		end
	end

endmodule

/* hw/gcpPulseGen.sv */
// Gradient control pulse generator keyed on the bit index.
module gcpPulseGen
	import vfdPkg::*;
(
	input  logic   CLK,
	input  logic   arstN,
	input  bitIdxT bitIdx,
	input  logic   sck,
	input  logic   loadActive,
	output logic   gcp
);

	logic sckPrev;
	logic bitEdge;  // Serial clock just fell.
	logic hitStart;
	logic hitEnd;

	assign bitEdge = sckPrev & ~sck;

	always_comb begin
		hitStart = 1'b0;
		hitEnd   = 1'b0;
		for (int i = 0; i < $size(gcpStarts); i++) begin
			if (bitIdx == bitIdxT'(gcpStarts[i]))
				hitStart = 1'b1;
			if (bitIdx == bitIdxT'(gcpStarts[i] + gcpWidth))
				hitEnd = 1'b1;
		end
	end

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			sckPrev <= 1'b0;
			gcp     <= 1'b0;
		end else if (loadActive) begin
			sckPrev <= 1'b0;
			gcp     <= 1'b0;
		end else begin
			sckPrev <= sck;
			if (bitEdge && hitStart)
				gcp <= 1'b1; // Rises with clockLow of the start bit.
			else if (bitEdge && hitEnd)
				gcp <= 1'b0;
		end
	end

endmodule

/* hw/vfdTop.sv */
// VFD frame buffer top: SPI loader, frame RAM, scan sequencer, pixel path and GCP.
module vfdTop
	import vfdPkg::*;
(
	input  logic CLK,
	input  logic arstN,
	input  logic sdi,
	input  logic sclk,
	input  logic csN,
	output grayT sData,
	output logic blk,
	output logic lat,
	output logic sck,
	output logic gcp,
	output logic eof
);

	// Host write side.
	logic       wrEn;
	ramAddrT    wrAddr;
	ramByteT    wrData;
	logic       loadActive;
	// Scan read side.
	logic       rdEn;
	ramAddrT    rdAddr;
	ramByteT    rdData;
	gridT       grid;
	bitIdxT     bitIdx;
	pixSlotT    pixSlot;
	logic [5:0] row;
	logic       fetchStb;

	spiFrameLoader spiLoader (
		.CLK       (CLK),
		.arstN     (arstN),
		.sdi       (sdi),
		.sclk      (sclk),
		.csN       (csN),
		.wrEn      (wrEn),
		.wrAddr    (wrAddr),
		.wrData    (wrData),
		.loadActive(loadActive)
	);

	frameRam frameMem (
		.CLK   (CLK),
		.wrEn  (wrEn),
		.wrAddr(wrAddr),
		.wrData(wrData),
		.rdEn  (rdEn),
		.rdAddr(rdAddr),
		.rdData(rdData)
	);

	gridSequencer scanSeq (
		.CLK       (CLK),
		.arstN     (arstN),
		.loadActive(loadActive),
		.grid      (grid),
		.bitIdx    (bitIdx),
		.pixSlot   (pixSlot),
		.row       (row),
		.fetchStb  (fetchStb),
		.blk       (blk),
		.lat       (lat),
		.sck       (sck),
		.eof       (eof)
	);

	pixelFetch pixFetch (
		.CLK     (CLK),
		.arstN   (arstN),
		.grid    (grid),
		.bitIdx  (bitIdx),
		.pixSlot (pixSlot),
		.row     (row),
		.fetchStb(fetchStb),
		.rdData  (rdData),
		.rdEn    (rdEn),
		.rdAddr  (rdAddr),
		.sData   (sData)
	);

	gcpPulseGen gcpGen (
		.CLK       (CLK),
		.arstN     (arstN),
		.bitIdx    (bitIdx),
		.sck       (sck),
		.loadActive(loadActive),
		.gcp       (gcp)
	);

endmodule

/* verif/vfdTop_assertions.sv */
// Concurrent checks on the top-level latch, serial clock and end-of-frame outputs.
module vfdTopAssertions (
	input logic CLK,
	input logic arstN,
	input logic blk,
	input logic lat,
	input logic sck,
	input logic eof
);

	int failCount = 0; // Failed assertions so far.

	// Latch pulse sits inside the blank phase.
	latInBlank: assert property (@(posedge CLK) disable iff (!arstN) lat |-> blk)
		else begin
			failCount++;
			$error("lat high while blk is low");
		end

	// No shifting into a blanked tube.
	sckNotBlanked: assert property (@(posedge CLK) disable iff (!arstN) $rose(sck) |-> !blk)
		else begin
			failCount++;
			$error("sck rose while blk is high");
		end

	eofOneCycle: assert property (@(posedge CLK) disable iff (!arstN) $rose(eof) |=> !eof)
		else begin
			failCount++;
			$error("eof stayed high longer than one cycle");
		end

endmodule

/* verif/vfdChecker.sv */
// Scan reference model and comparator for pixel and grid-enable bits, GCP, blank, latch and eof.
module vfdChecker
	import vfdPkg::*;
(
	input  logic CLK,
	input  logic csN,
	input  grayT sData,
	input  logic blk,
	input  logic lat,
	input  logic sck,
	input  logic gcp,
	input  logic eof,
	output int   errCount,
	output int   frameCount
);

	// Per slot in A F B E C D order the byte within the pair, upper half and odd-grid flag.
	localparam int slotByte  [0:5] = '{0, 2, 0, 2, 1, 1};
	localparam bit slotUpper [0:5] = '{1, 0, 0, 1, 1, 0};
	localparam bit slotOdd   [0:5] = '{1, 0, 1, 0, 1, 0};
	localparam int gcpBits   [0:5] = '{72, 144, 192, 216, 240, 256}; // GCP schedule.

	logic [gridCount:0] seenGrids [frameBytes]; // Grids in which a byte was compared.
	logic [3:0] csHist;    // Last four chip select samples.
	logic       armed = 1'b0; // Set once a load has begun.
	logic       latPrev;
	logic       sckPrev;
	logic       gcpPrev;
	logic       eofPrev;
	grayT       sDataPrev; // Serial data just before the sck rise.
	int         gridNo;    // Grid being shifted or 0 between frames.
	int         bitCnt;    // sck rises so far in this grid.
	int         gcpRises;
	int         gcpFrom;   // Bit of the last GCP rise.

	initial begin
		errCount   = 0;
		frameCount = 0;
		gridNo     = 0;
		bitCnt     = 0;
		gcpRises   = 0;
		csHist     = '1;
		for (int a = 0; a < frameBytes; a++)
			seenGrids[a] = '0;
	end

	// ==================================================
	// Reference rules.
	// ==================================================
	function automatic int byteAddr(input int g, input int b);
		return slotByte[b % 6] + ((g - 1) / 2) * 3 + (b / 6) * rowBytes;
	endfunction

	function automatic logic shown(input int g, input int b);
		return slotOdd[b % 6] == (g % 2 == 1); // Parity mask.
	endfunction

	function automatic grayT expectBit(input int g, input int b);
		logic [7:0] val;
		if (b >= pixelBits)
			return ((b == 233 + g) || (b == 234 + g)) ? 3'b111 : 3'b000;
		if (!shown(g, b))
			return 3'b000;
		val = (byteAddr(g, b) < frameBytes) ? vfdTb.frameModel[byteAddr(g, b)] : 8'h00;
		return slotUpper[b % 6] ? val[5:3] : val[2:0];
	endfunction

	function automatic logic isGcpStart(input int b);
		logic hit = 1'b0;
		for (int i = 0; i < 6; i++)
			if (gcpBits[i] == b)
				hit = 1'b1;
		return hit;
	endfunction

	// Table name for a failing byte, if it has one.
	function automatic string entryName(input int addr);
		string name = "pixel";
		for (int i = 0; i < 5; i++)
			if (vfdTb.tblAddr[i] == addr)
				name = vfdTb.tblName[i];
		return name;
	endfunction

	// ==================================================
	// One sample of a running scan.
	// ==================================================
	task automatic scanStep();
		grayT  exp;
		string name;
		if (eof && !eofPrev) begin
			if (gridNo != gridCount || bitCnt != bitsPerGrid || gcpRises != 6) begin
				errCount++;
				$display("eof came at grid %0d after %0d bits and %0d GCP pulses",
					gridNo, bitCnt, gcpRises);
			end
			frameCount++;
			gridNo = 0; // Next latch opens grid 1.
		end
		if (lat && !latPrev) begin
			if (!blk) begin
				errCount++;
				$display("lat rose while blk was low");
			end
			if (gridNo != 0 && bitCnt != bitsPerGrid) begin
				errCount++;
				$display("[FAIL] sckCount grid %0d: expected %0d, actual %0d",
					gridNo, bitsPerGrid, bitCnt);
			end
			if (gridNo != 0 && gcpRises != 6) begin
				errCount++;
				$display("[FAIL] gcpCount grid %0d: expected 6, actual %0d", gridNo, gcpRises);
			end
			if (gridNo == gridCount) begin
				errCount++;
				$display("grid %0d ended without an eof pulse", gridCount);
			end
			gridNo   = (gridNo == gridCount) ? 1 : gridNo + 1;
			bitCnt   = 0;
			gcpRises = 0;
		end
		if (gcp && !gcpPrev) begin
			if (!isGcpStart(bitCnt)) begin
				errCount++;
				$display("[FAIL] gcpRise grid %0d: expected a start bit, actual bit %0d",
					gridNo, bitCnt);
			end
			gcpFrom = bitCnt;
			gcpRises++;
		end
		if (!gcp && gcpPrev && bitCnt != gcpFrom + 3) begin
			errCount++;
			$display("[FAIL] gcpFall grid %0d: expected bit %0d, actual bit %0d",
				gridNo, gcpFrom + 3, bitCnt);
		end
		if (sck && !sckPrev) begin
			exp  = expectBit(gridNo, bitCnt);
			name = (bitCnt < pixelBits) ? entryName(byteAddr(gridNo, bitCnt)) : "gridEnable";
			if (gridNo == 0 || blk) begin
				errCount++;
				$display("sck rose outside the bit phase of a grid");
			end else if (sData !== exp) begin
				errCount++;
				$display("[FAIL] %s grid %0d bit %0d: expected %b, actual %b",
					name, gridNo, bitCnt, exp, sData);
			end else if (sDataPrev !== exp) begin
				errCount++;
				$display("[FAIL] %s setup grid %0d bit %0d: expected %b, actual %b",
					name, gridNo, bitCnt, exp, sDataPrev);
			end
			if (gridNo != 0 && bitCnt < pixelBits && shown(gridNo, bitCnt)
					&& byteAddr(gridNo, bitCnt) < frameBytes)
				seenGrids[byteAddr(gridNo, bitCnt)][gridNo] = 1'b1;
			bitCnt++;
		end
	endtask

	always @(posedge CLK) begin
		if (!csN) begin
			gridNo   = 0; // Scan restarts at grid 1 after the load.
			bitCnt   = 0;
			gcpRises = 0;
			armed    = 1'b1;
			if (csHist == 4'b0000 && (blk !== 1'b1 || sck !== 1'b0 || gcp !== 1'b0)) begin
				errCount++;
				$display("[FAIL] hold: expected blk=1 sck=0 gcp=0, actual blk=%b sck=%b gcp=%b",
					blk, sck, gcp);
			end
		end else if (armed && csHist == 4'b1111) begin
			scanStep(); // Synchronizer delay has passed.
		end
		csHist    = {csHist[2:0], csN};
		latPrev   = lat;
		sckPrev   = sck;
		gcpPrev   = gcp;
		eofPrev   = eof;
		sDataPrev = sData;
	end

endmodule

/* verif/vfdTb.sv */
// VFD testbench: clock, reset, stimulus table, SPI frame load, timeout and final report.
module vfdTb
	import vfdPkg::*;
();

	localparam int gridCycles    = blankLen + 3 * bitsPerGrid; // 871 cycles.
	localparam int timeoutCycles = frameBytes * 64 + 2 * gridCount * gridCycles + 1000;

	logic       CLK;
	logic       arstN;
	logic       sdi;
	logic       sclk;
	logic       csN;
	grayT       sData;
	logic       blk;
	logic       lat;
	logic       sck;
	logic       gcp;
	logic       eof;
	int         errCount;   // From the checker.
	int         frameCount; // Frames seen by the checker.
	int         tbErrors = 0;
	int         cycleCount = 0;
	int         seed = 35963;
	logic [7:0] frameModel [frameBytes]; // Bytes as sent to the host port.

	// ==================================================
	// Stimulus table.
	// ==================================================
	string      tblName  [0:4] = '{"cornerOdd", "cornerEven", "lastByte", "midRow", "zero"};
	int         tblAddr  [0:4] = '{0, 2, 3002, 1540, 5};
	logic [7:0] tblValue [0:4] = '{8'h3F, 8'h38, 8'h2A, 8'h15, 8'h00};
	int         tblGrid  [0:4] = '{1, 2, 51, 1, 4}; // Grid that shows the entry.

	vfdTop dut_i (
		.CLK  (CLK),
		.arstN(arstN),
		.sdi  (sdi),
		.sclk (sclk),
		.csN  (csN),
		.sData(sData),
		.blk  (blk),
		.lat  (lat),
		.sck  (sck),
		.gcp  (gcp),
		.eof  (eof)
	);

	vfdChecker scanCheck (
		.CLK       (CLK),
		.csN       (csN),
		.sData     (sData),
		.blk       (blk),
		.lat       (lat),
		.sck       (sck),
		.gcp       (gcp),
		.eof       (eof),
		.errCount  (errCount),
		.frameCount(frameCount)
	);

	bind vfdTop vfdTopAssertions assertChk (
		.CLK  (CLK),
		.arstN(arstN),
		.blk  (blk),
		.lat  (lat),
		.sck  (sck),
		.eof  (eof)
	);

	initial begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK; // Period 40.
	end

	// One byte, MSB first, 4 clocks per sclk half period.
	task automatic sendByte(input logic [7:0] value);
		for (int i = 7; i >= 0; i--) begin
			sdi = value[i]; // Changes while sclk is low.
			repeat (4) @(posedge CLK);
			#2 sclk = 1'b1;
			repeat (4) @(posedge CLK);
			#2 sclk = 1'b0;
		end
	endtask

	task automatic loadFrame();
		@(posedge CLK);
		#2 csN = 1'b0;
		for (int a = 0; a < frameBytes; a++)
			sendByte(frameModel[a]);
		repeat (4) @(posedge CLK); // Last RAM write lands.
		#2 csN = 1'b1;
	endtask

	// Run limit: load, two scanned frames and some slack.
	initial begin
		while (cycleCount < timeoutCycles) begin
			@(posedge CLK);
			cycleCount++;
		end
		$display("Timeout: two frames were not scanned within %0d clock cycles", timeoutCycles);
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		int total;
		arstN = 1'b0;
		sdi   = 1'b0;
		sclk  = 1'b0;
		csN   = 1'b1; // Host idle.
		repeat (10) @(posedge CLK);
		#2 arstN = 1'b1;
		for (int a = 0; a < frameBytes; a++)
			frameModel[a] = 8'($random(seed));
		for (int i = 0; i < 5; i++)
			frameModel[tblAddr[i]] = tblValue[i]; // Table overrides the random fill.
		loadFrame();
		wait (frameCount >= 2);
		for (int i = 0; i < 5; i++) begin
			if (!scanCheck.seenGrids[tblAddr[i]][tblGrid[i]]) begin
				tbErrors++;
				$display("Table entry %s at address %0d was never shifted out in grid %0d",
					tblName[i], tblAddr[i], tblGrid[i]);
			end
		end
		total = errCount + tbErrors + dut_i.assertChk.failCount;
		$display("Summary: %0d checker errors, %0d table errors, %0d assertion failures",
			errCount, tbErrors, dut_i.assertChk.failCount);
		if (total == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

/* sources.f */
hw/vfdPkg.sv
hw/spiFrameLoader.sv
hw/frameRam.sv
hw/gridSequencer.sv
hw/pixelFetch.sv
hw/gcpPulseGen.sv
hw/vfdTop.sv
verif/vfdTop_assertions.sv
verif/vfdChecker.sv
verif/vfdTb.sv
